// ==== logic/irq_pkg.sv ====
package irq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt source map
  ////////////////////////////////////////////////////////////////////////////

  // Total source IDs, ID 0 is reserved and never raised
  localparam int IRQ_TOTAL = 16;
  // Bits needed to name any source
  localparam int IRQ_ID_WIDTH = $clog2(IRQ_TOTAL);

  // Number of GPIO pins that can raise interrupts
  localparam int GPIO_WIDTH = 12;
  // First GPIO source ID, pins take IDs 1..12
  localparam int IRQ_GPIO_BASE = 1;
  // Software interrupt source, IDs above it are tied low
  localparam int IRQ_SOFT_ID = 13;

  // Priority width, priority 0 disables a source
  localparam int PRIO_WIDTH = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Shared types
  ////////////////////////////////////////////////////////////////////////////

  // One bit per source ID
  typedef logic [IRQ_TOTAL-1:0] irq_vec_t;
  // Source ID, 0 means no source
  typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;
  // Priority or threshold value
  typedef logic [PRIO_WIDTH-1:0] prio_t;
  // One bit per GPIO pin
  typedef logic [GPIO_WIDTH-1:0] gpio_t;

  // Per-source gateway state
  typedef enum logic [1:0] {
    GW_IDLE       = 2'd0,
    GW_PENDING    = 2'd1,
    GW_IN_SERVICE = 2'd2
  } gw_state_e;

endpackage

// ==== logic/gpio_irq_sense.sv ====
`timescale 1ns/1ps

module gpio_irq_sense (
  // System clock and async reset
  input  logic           i_sys_clk,
  input  logic           i_arst_n,
  // Raw pin levels, not yet in the clock domain
  input  irq_pkg::gpio_t i_gpio,
  // Per-pin interrupt enable level
  input  irq_pkg::gpio_t i_gpio_ena,
  // One-cycle interrupt pulses, one per pin
  output irq_pkg::gpio_t o_irq
);

  // First synchronizer stage, may go metastable
  irq_pkg::gpio_t sync1_q;
  // Second synchronizer stage, safe to use
  irq_pkg::gpio_t sync2_q;
  // Level seen one cycle earlier
  irq_pkg::gpio_t prev_q;
  // Enabled rising edges of this cycle
  irq_pkg::gpio_t rise;

  ////////////////////////////////////////////////////////////////////////////
  // Two-stage synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin : sync_proc
    if (!i_arst_n)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
    end
    else
    begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
    end
  end : sync_proc

  ////////////////////////////////////////////////////////////////////////////
  // Rising edge detect
  ////////////////////////////////////////////////////////////////////////////

  // Edge needs low-to-high between prev_q and sync2_q
  // Enable only masks, so toggling it alone never makes an edge
  assign rise = sync2_q & ~prev_q & i_gpio_ena;

  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin : edge_proc
    if (!i_arst_n)
    begin
      prev_q <= '0;
      o_irq  <= '0;
    end
    else
    begin
      // prev_q follows sync2_q, so a held level pulses only once
      prev_q <= sync2_q;
      // Registered pulse, third cycle after the pin change
      o_irq  <= rise;
    end
  end : edge_proc

endmodule

// ==== logic/plic_gateway.sv ====
`timescale 1ns/1ps

module plic_gateway (
  // System clock and async reset
  input  logic              i_sys_clk,
  input  logic              i_arst_n,
  // Interrupt pulses, bit 0 unused
  input  irq_pkg::irq_vec_t i_src_irq,
  // Claim strobe for the source named by the target
  input  logic              i_claim,
  input  irq_pkg::irq_id_t  i_claim_id,
  // Completion strobe with the finished source
  input  logic              i_complete,
  input  irq_pkg::irq_id_t  i_complete_id,
  // Sources waiting for a claim
  output irq_pkg::irq_vec_t o_pending
);

  // Current and next state of every source
  irq_pkg::gw_state_e state_q [irq_pkg::IRQ_TOTAL];
  irq_pkg::gw_state_e state_d [irq_pkg::IRQ_TOTAL];

  ////////////////////////////////////////////////////////////////////////////
  // Per-source state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin : next_proc
    for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
    begin
      state_d[i] = state_q[i];
      case (state_q[i])
        irq_pkg::GW_IDLE:
        begin
          // New request latched
          if (i_src_irq[i])
          begin
            state_d[i] = irq_pkg::GW_PENDING;
          end
        end
        irq_pkg::GW_PENDING:
        begin
          // Further pulses dropped, only a claim moves it on
          if (i_claim && (i_claim_id == irq_pkg::irq_id_t'(i)))
          begin
            state_d[i] = irq_pkg::GW_IN_SERVICE;
          end
        end
        irq_pkg::GW_IN_SERVICE:
        begin
          // Handler done, source may fire again
          if (i_complete && (i_complete_id == irq_pkg::irq_id_t'(i)))
          begin
            state_d[i] = irq_pkg::GW_IDLE;
          end
        end
        default:
        begin
          state_d[i] = irq_pkg::GW_IDLE;
        end
      endcase
    end
    // ID 0 means no interrupt, keep it out of the FSM
    state_d[0] = irq_pkg::GW_IDLE;
  end : next_proc

  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin : state_proc
    if (!i_arst_n)
    begin
      for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
      begin
        state_q[i] <= irq_pkg::GW_IDLE;
      end
    end
    else
    begin
      for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
      begin
        state_q[i] <= state_d[i];
      end
    end
  end : state_proc

  // Pending vector straight from the state registers
  always_comb
  begin : pend_proc
    for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
    begin
      o_pending[i] = (state_q[i] == irq_pkg::GW_PENDING);
    end
  end : pend_proc

endmodule

// ==== logic/plic_target.sv ====
`timescale 1ns/1ps

module plic_target (
  // System clock and async reset
  input  logic              i_sys_clk,
  input  logic              i_arst_n,
  // Pending sources from the gateway
  input  irq_pkg::irq_vec_t i_pending,
  // Priority register write
  input  logic              i_prio_we,
  input  irq_pkg::irq_id_t  i_prio_id,
  input  irq_pkg::prio_t    i_prio_val,
  // Threshold register write
  input  logic              i_thresh_we,
  input  irq_pkg::prio_t    i_thresh_val,
  // Best source above threshold, 0 if none
  output irq_pkg::irq_id_t  o_claim_id,
  // Machine external interrupt level
  output logic              o_meip
);

  // Priority per source and the hart threshold
  irq_pkg::prio_t   prio_q [irq_pkg::IRQ_TOTAL];
  irq_pkg::prio_t   thresh_q;
  // Scan result
  irq_pkg::prio_t   best_prio;
  irq_pkg::irq_id_t best_id;
  // Claim ID after the threshold check
  irq_pkg::irq_id_t claim_d;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin : cfg_proc
    if (!i_arst_n)
    begin
      for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
      begin
        prio_q[i] <= '0;
      end
      thresh_q <= '0;
    end
    else
    begin
      // One priority per write strobe
      if (i_prio_we)
      begin
        prio_q[i_prio_id] <= i_prio_val;
      end
      if (i_thresh_we)
      begin
        thresh_q <= i_thresh_val;
      end
    end
  end : cfg_proc

  ////////////////////////////////////////////////////////////////////////////
  // Best pending source
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin : scan_proc
    best_prio = '0;
    best_id   = '0;
    // Ascending scan with strict compare
    // lower ID wins a tie, priority 0 never wins
    for (int i = 1; i < irq_pkg::IRQ_TOTAL; i++)
    begin
      if (i_pending[i] && (prio_q[i] > best_prio))
      begin
        best_prio = prio_q[i];
        best_id   = irq_pkg::irq_id_t'(i);
      end
    end
    // Must beat the threshold to interrupt the hart
    if (best_prio > thresh_q)
    begin
      claim_d = best_id;
    end
    else
    begin
      claim_d = '0;
    end
  end : scan_proc

  ////////////////////////////////////////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_sys_clk or negedge i_arst_n)
  begin : out_proc
    if (!i_arst_n)
    begin
      o_claim_id <= '0;
      o_meip     <= 1'b0;
    end
    else
    begin
      o_claim_id <= claim_d;
      // Same compare as the ID, so meip tracks claim_id != 0
      o_meip     <= (claim_d != '0);
    end
  end : out_proc

endmodule

// ==== logic/irq_soc.sv ====
`timescale 1ns/1ps

module irq_soc (
  // System clock and async reset
  input  logic             i_sys_clk,
  input  logic             i_arst_n,
  // GPIO pins and their interrupt enables
  input  irq_pkg::gpio_t   i_gpio,
  input  irq_pkg::gpio_t   i_gpio_ena,
  // Software interrupt pulse
  input  logic             i_soft_irq,
  // Priority write
  input  logic             i_prio_we,
  input  irq_pkg::irq_id_t i_prio_id,
  input  irq_pkg::prio_t   i_prio_val,
  // Threshold write
  input  logic             i_thresh_we,
  input  irq_pkg::prio_t   i_thresh_val,
  // Claim and complete strobes from the hart
  input  logic             i_claim,
  input  logic             i_complete,
  input  irq_pkg::irq_id_t i_complete_id,
  // Claim ID and external interrupt to the hart
  output irq_pkg::irq_id_t o_claim_id,
  output logic             o_meip
);

  // GPIO edge pulses
  irq_pkg::gpio_t    gpio_irq;
  // Full source vector into the gateway
  irq_pkg::irq_vec_t src_irq;
  // Gateway pending bits
  irq_pkg::irq_vec_t pending;
  // Claim ID, also fed back to the gateway
  irq_pkg::irq_id_t  claim_id;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt sources
  ////////////////////////////////////////////////////////////////////////////

  gpio_irq_sense sense0 (
    .i_sys_clk  (i_sys_clk),
    .i_arst_n   (i_arst_n),
    .i_gpio     (i_gpio),
    .i_gpio_ena (i_gpio_ena),
    .o_irq      (gpio_irq)
  );

  always_comb
  begin : src_proc
    // ID 0 and unused IDs stay low
    src_irq = '0;
    src_irq[irq_pkg::IRQ_GPIO_BASE +: irq_pkg::GPIO_WIDTH] = gpio_irq;
    src_irq[irq_pkg::IRQ_SOFT_ID] = i_soft_irq;
  end : src_proc

  ////////////////////////////////////////////////////////////////////////////
  // Gateway and target
  ////////////////////////////////////////////////////////////////////////////

  plic_gateway gw0 (
    .i_sys_clk     (i_sys_clk),
    .i_arst_n      (i_arst_n),
    .i_src_irq     (src_irq),
    .i_claim       (i_claim),
    .i_claim_id    (claim_id),
    .i_complete    (i_complete),
    .i_complete_id (i_complete_id),
    .o_pending     (pending)
  );

  plic_target tgt0 (
    .i_sys_clk    (i_sys_clk),
    .i_arst_n     (i_arst_n),
    .i_pending    (pending),
    .i_prio_we    (i_prio_we),
    .i_prio_id    (i_prio_id),
    .i_prio_val   (i_prio_val),
    .i_thresh_we  (i_thresh_we),
    .i_thresh_val (i_thresh_val),
    .o_claim_id   (claim_id),
    .o_meip       (o_meip)
  );

  // Hart sees the ID it claims
  assign o_claim_id = claim_id;

endmodule

// ==== tb/irq_model.svh ====
`ifndef IRQ_MODEL_SVH
`define IRQ_MODEL_SVH

// Priority table, one entry per source ID
typedef logic [irq_pkg::IRQ_TOTAL-1:0][irq_pkg::PRIO_WIDTH-1:0] prio_tab_t;

// Next gateway state of one source
// pulse only counts in idle, claim only in pending, complete only in service
function automatic irq_pkg::gw_state_e gw_next(
  input irq_pkg::gw_state_e cur,
  input logic               pulse,
  input logic               claim_hit,
  input logic               complete_hit
);
  gw_next = cur;
  if ((cur == irq_pkg::GW_IDLE) && pulse)
    gw_next = irq_pkg::GW_PENDING;
  else if ((cur == irq_pkg::GW_PENDING) && claim_hit)
    gw_next = irq_pkg::GW_IN_SERVICE;
  else if ((cur == irq_pkg::GW_IN_SERVICE) && complete_hit)
    gw_next = irq_pkg::GW_IDLE;
endfunction

// Pins that went low to high between two delayed levels, masked by enable
function automatic irq_pkg::gpio_t edge_pulses(
  input irq_pkg::gpio_t level,
  input irq_pkg::gpio_t prev_level,
  input irq_pkg::gpio_t ena
);
  edge_pulses = level & ~prev_level & ena;
endfunction

// Best pending source above the threshold, 0 if none
function automatic irq_pkg::irq_id_t expected_claim(
  input irq_pkg::irq_vec_t pend,
  input prio_tab_t         prio,
  input irq_pkg::prio_t    thresh
);
  irq_pkg::prio_t   top;
  irq_pkg::irq_id_t id;
  top = '0;
  id  = '0;
  // Walk down from the top ID, >= lets the lower ID take a tie
  for (int i = irq_pkg::IRQ_TOTAL - 1; i >= 1; i--)
  begin
    if (pend[i] && (prio[i] > thresh) && (prio[i] >= top))
    begin
      top = prio[i];
      id  = irq_pkg::irq_id_t'(i);
    end
  end
  expected_claim = id;
endfunction

`endif

// ==== tb/irq_soc_tb.sv ====
`timescale 1ns/1ps

module irq_soc_tb;

  logic              i_sys_clk;
  logic              i_arst_n;
  irq_pkg::gpio_t    i_gpio;
  irq_pkg::gpio_t    i_gpio_ena;
  logic              i_soft_irq;
  logic              i_prio_we;
  irq_pkg::irq_id_t  i_prio_id;
  irq_pkg::prio_t    i_prio_val;
  logic              i_thresh_we;
  irq_pkg::prio_t    i_thresh_val;
  logic              i_claim;
  logic              i_complete;
  irq_pkg::irq_id_t  i_complete_id;
  irq_pkg::irq_id_t  o_claim_id;
  logic              o_meip;

`include "irq_model.svh"

  // Model registers, one per DUT register stage
  irq_pkg::gpio_t     m_sync1;
  irq_pkg::gpio_t     m_sync2;
  irq_pkg::gpio_t     m_prev;
  irq_pkg::gpio_t     m_pulse;
  irq_pkg::gw_state_e m_gw [irq_pkg::IRQ_TOTAL];
  prio_tab_t          m_prio;
  irq_pkg::prio_t     m_thresh;
  irq_pkg::irq_id_t   m_claim;
  // Last source the model saw claimed
  irq_pkg::irq_id_t   m_last_svc;
  irq_pkg::irq_vec_t  m_src;
  irq_pkg::irq_vec_t  m_pend;
  irq_pkg::irq_id_t   m_next;

  integer            seed;
  logic [31:0]       rnd;
  logic [31:0]       rnd2;
  int                pin;
  int                guard;
  int                checks;
  int                mismatches;
  int                fails;
  irq_pkg::irq_id_t  got;
  irq_pkg::irq_id_t  svc;
  irq_pkg::prio_t    top;

  irq_soc dut (
    .i_sys_clk     (i_sys_clk),
    .i_arst_n      (i_arst_n),
    .i_gpio        (i_gpio),
    .i_gpio_ena    (i_gpio_ena),
    .i_soft_irq    (i_soft_irq),
    .i_prio_we     (i_prio_we),
    .i_prio_id     (i_prio_id),
    .i_prio_val    (i_prio_val),
    .i_thresh_we   (i_thresh_we),
    .i_thresh_val  (i_thresh_val),
    .i_claim       (i_claim),
    .i_complete    (i_complete),
    .i_complete_id (i_complete_id),
    .o_claim_id    (o_claim_id),
    .o_meip        (o_meip)
  );

  // 100 ns period
  always #50 i_sys_clk = ~i_sys_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model stepped on the same edges as the DUT
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge i_sys_clk or negedge i_arst_n)
  begin : model_proc
    if (!i_arst_n)
    begin
      m_sync1 = '0;
      m_sync2 = '0;
      m_prev = '0;
      m_pulse = '0;
      for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
        m_gw[i] = irq_pkg::GW_IDLE;
      m_prio = '0;
      m_thresh = '0;
      m_claim = '0;
      m_last_svc = '0;
    end
    else
    begin
      // GPIO at 1..12 and soft at 13 with the rest low
      m_src = '0;
      m_src[irq_pkg::IRQ_GPIO_BASE +: irq_pkg::GPIO_WIDTH] = m_pulse;
      m_src[irq_pkg::IRQ_SOFT_ID] = i_soft_irq;
      for (int i = 0; i < irq_pkg::IRQ_TOTAL; i++)
        m_pend[i] = (m_gw[i] == irq_pkg::GW_PENDING);
      // Target output follows last cycle's pending, priorities and threshold
      m_next = expected_claim(m_pend, m_prio, m_thresh);
      if (i_claim && (m_claim != '0))
        m_last_svc = m_claim;
      for (int i = 1; i < irq_pkg::IRQ_TOTAL; i++)
        m_gw[i] = gw_next(m_gw[i], m_src[i],
                          i_claim && (m_claim == irq_pkg::irq_id_t'(i)),
                          i_complete && (i_complete_id == irq_pkg::irq_id_t'(i)));
      m_claim = m_next;
      if (i_prio_we)
        m_prio[i_prio_id] = i_prio_val;
      if (i_thresh_we)
        m_thresh = i_thresh_val;
      // Pin delay line with the pulse out of the edge stage
      m_pulse = edge_pulses(m_sync2, m_prev, i_gpio_ena);
      m_prev = m_sync2;
      m_sync2 = m_sync1;
      m_sync1 = i_gpio;
    end
  end : model_proc

  // Outputs are stable at the falling edge
  always @(negedge i_sys_clk)
  begin : compare_proc
    checks++;
    assert (o_claim_id == m_claim)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: o_claim_id is %0d, expected %0d", $time, o_claim_id, m_claim);
    end
    assert (o_meip == (m_claim != '0))
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: o_meip is %0b, expected %0b", $time, o_meip, m_claim != '0);
    end
  end : compare_proc

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cycles(input int n);
    repeat (n) @(posedge i_sys_clk);
  endtask

  task automatic write_prio(input irq_pkg::irq_id_t id, input irq_pkg::prio_t val);
    @(posedge i_sys_clk);
    i_prio_we <= 1'b1;
    i_prio_id <= id;
    i_prio_val <= val;
    @(posedge i_sys_clk);
    i_prio_we <= 1'b0;
  endtask

  task automatic write_thresh(input irq_pkg::prio_t val);
    @(posedge i_sys_clk);
    i_thresh_we <= 1'b1;
    i_thresh_val <= val;
    @(posedge i_sys_clk);
    i_thresh_we <= 1'b0;
  endtask

  task automatic soft_pulse();
    @(posedge i_sys_clk);
    i_soft_irq <= 1'b1;
    @(posedge i_sys_clk);
    i_soft_irq <= 1'b0;
  endtask

  // Returns the ID that the claim strobe takes
  task automatic claim_once(output irq_pkg::irq_id_t id);
    @(posedge i_sys_clk);
    i_claim <= 1'b1;
    @(negedge i_sys_clk);
    id = o_claim_id;
    @(posedge i_sys_clk);
    i_claim <= 1'b0;
  endtask

  task automatic complete_src(input irq_pkg::irq_id_t id);
    @(posedge i_sys_clk);
    i_complete <= 1'b1;
    i_complete_id <= id;
    @(posedge i_sys_clk);
    i_complete <= 1'b0;
  endtask

  task automatic wait_meip(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge i_sys_clk);
    while ((o_meip !== level) && (n < limit))
    begin
      @(negedge i_sys_clk);
      n++;
    end
    assert (o_meip === level)
    else
    begin
      fails++;
      $display("Timeout at %0t: o_meip never went to %0b within %0d cycles", $time, level, limit);
    end
  endtask

  task automatic expect_claim(input irq_pkg::irq_id_t exp);
    @(negedge i_sys_clk);
    assert (o_claim_id == exp)
    else
    begin
      fails++;
      $display("Mismatch at %0t: o_claim_id is %0d, expected %0d", $time, o_claim_id, exp);
    end
    assert (o_meip == (exp != '0))
    else
    begin
      fails++;
      $display("Mismatch at %0t: o_meip is %0b, expected %0b", $time, o_meip, exp != '0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    i_sys_clk = 1'b0;
    seed = 32'h49a2;
    i_arst_n <= 1'b0;
    i_gpio <= '0;
    i_gpio_ena <= '0;
    i_soft_irq <= 1'b0;
    i_prio_we <= 1'b0;
    i_prio_id <= '0;
    i_prio_val <= '0;
    i_thresh_we <= 1'b0;
    i_thresh_val <= '0;
    i_claim <= 1'b0;
    i_complete <= 1'b0;
    i_complete_id <= '0;
    run_cycles(3);
    i_arst_n <= 1'b1;
    run_cycles(2);
    expect_claim('0);

    // Selectable GPIO sources make any pulse with a low enable visible
    for (int id = irq_pkg::IRQ_GPIO_BASE; id < irq_pkg::IRQ_SOFT_ID; id++)
    begin
      write_prio(irq_pkg::irq_id_t'(id), 3'd2);
    end

    // Pins toggle while every enable is low
    repeat (8)
    begin
      rnd = $random(seed);
      @(posedge i_sys_clk);
      i_gpio <= rnd[11:0];
    end
    @(posedge i_sys_clk);
    i_gpio <= '0;
    run_cycles(6);
    expect_claim('0);

    // Single pin edge then held level and falling edge
    rnd = $random(seed);
    pin = int'(rnd[3:0]) % irq_pkg::GPIO_WIDTH;
    write_prio(irq_pkg::irq_id_t'(irq_pkg::IRQ_GPIO_BASE + pin), 3'd5);
    @(posedge i_sys_clk);
    i_gpio_ena <= irq_pkg::gpio_t'(1) << pin;
    run_cycles(2);
    i_gpio[pin] <= 1'b1;
    wait_meip(1'b1, 8);
    expect_claim(irq_pkg::irq_id_t'(irq_pkg::IRQ_GPIO_BASE + pin));
    claim_once(got);
    complete_src(got);
    run_cycles(8);
    expect_claim('0);
    i_gpio[pin] <= 1'b0;
    run_cycles(8);
    expect_claim('0);

    // Random priorities with the soft source kept above zero
    for (int id = 1; id < irq_pkg::IRQ_TOTAL; id++)
    begin
      rnd = $random(seed);
      write_prio(irq_pkg::irq_id_t'(id), rnd[2:0]);
    end
    write_prio(irq_pkg::irq_id_t'(irq_pkg::IRQ_SOFT_ID), 3'd4);
    @(posedge i_sys_clk);
    i_gpio_ena <= '1;
    rnd = $random(seed);
    @(posedge i_sys_clk);
    i_gpio <= rnd[11:0];
    soft_pulse();
    run_cycles(8);

    // Threshold at the best pending priority masks it
    @(negedge i_sys_clk);
    top = m_prio[m_claim];
    write_thresh(top);
    wait_meip(1'b0, 4);
    expect_claim('0);
    write_thresh('0);
    wait_meip(1'b1, 4);

    // Claim every selectable source in turn
    guard = 0;
    @(negedge i_sys_clk);
    while ((m_claim != '0) && (guard < irq_pkg::IRQ_TOTAL))
    begin
      claim_once(got);
      run_cycles(1);
      @(negedge i_sys_clk);
      guard++;
    end
    // Soft source in service drops the pulse
    soft_pulse();
    run_cycles(4);
    expect_claim('0);
    complete_src(irq_pkg::irq_id_t'(irq_pkg::IRQ_SOFT_ID));
    soft_pulse();
    wait_meip(1'b1, 6);
    expect_claim(irq_pkg::irq_id_t'(irq_pkg::IRQ_SOFT_ID));
    for (int id = 1; id < irq_pkg::IRQ_TOTAL; id++)
      complete_src(irq_pkg::irq_id_t'(id));

    // Random traffic on every input
    for (int k = 0; k < 400; k++)
    begin
      @(negedge i_sys_clk);
      rnd = $random(seed);
      rnd2 = $random(seed);
      svc = rnd2[3] ? m_last_svc : rnd2[7:4];
      @(posedge i_sys_clk);
      i_gpio <= i_gpio ^ (rnd[11:0] & rnd[23:12]);
      i_soft_irq <= (rnd[26:24] == 3'd0);
      i_claim <= (rnd[29:27] == 3'd0);
      if (rnd[31:30] == 2'b00)
        i_gpio_ena <= rnd2[31:20];
      i_complete <= (rnd2[2:0] == 3'd0);
      i_complete_id <= svc;
      i_prio_we <= (rnd2[11:8] == 4'd0);
      i_prio_id <= rnd2[15:12];
      i_prio_val <= rnd2[18:16];
      i_thresh_we <= rnd2[19] && (rnd2[11:8] == 4'd1);
      i_thresh_val <= {1'b0, rnd2[17:16]};
    end
    @(posedge i_sys_clk);
    i_soft_irq <= 1'b0;
    i_claim <= 1'b0;
    i_complete <= 1'b0;
    i_prio_we <= 1'b0;
    i_thresh_we <= 1'b0;
    run_cycles(4);

    $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, fails);
    if ((mismatches == 0) && (fails == 0))
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tb
logic/irq_pkg.sv
logic/gpio_irq_sense.sv
logic/plic_gateway.sv
logic/plic_target.sv
logic/irq_soc.sv
tb/irq_soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the irq_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module irq_soc_tb \
  --Mdir obj_dir -o irq_soc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/irq_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
